/* common/fc_pkg.sv */
package fc_pkg;

	// word format shared by pixels, weights, biases and results
	localparam int WORD_W = 16;

	// accumulator holds full products plus the aligned bias
	localparam int ACC_W = 32;

	// fixed point position inside a word
	localparam int FRAC_BITS = 8;

	// all buffer read addresses
	localparam int ADDR_W = 16;

	typedef logic signed [WORD_W-1:0] word_t;

	typedef logic signed [ACC_W-1:0] acc_t;

	// pixel read sequencer
	typedef enum logic [1:0]
	{
		seq_idle,
		seq_setting,
		seq_enable
	} seq_state_e;

	// bias fetch and hold
	typedef enum logic [1:0]
	{
		bias_idle,
		bias_loading,
		bias_ready
	} bias_state_e;

endpackage

/* common/fc_lane_if.sv */
interface fc_lane_if #(
	parameter int CHANNELS = 10
);
	import fc_pkg::*;

	// pixel is broadcast, weight and bias are one per channel
	word_t pixel;
	word_t weight [CHANNELS];
	word_t bias [CHANNELS];
	logic acc_first;
	logic acc_en;

	modport feeder (
		output pixel,
		output weight,
		output bias,
		output acc_first,
		output acc_en
	);

	modport lane (
		input pixel,
		input weight,
		input bias,
		input acc_first,
		input acc_en
	);

endinterface

/* design/fc_read_sequencer.sv */
module fc_read_sequencer #(
	parameter int ROWS = 5,
	parameter int COLS = 5
) (
	input logic clk,
	input logic rst,
	input logic start,
	output logic [fc_pkg::ADDR_W-1:0] row_addr,
	output logic [fc_pkg::ADDR_W-1:0] col_addr,
	output logic [fc_pkg::ADDR_W-1:0] weight_addr,
	output logic read_pixel_signal,
	output logic issue,
	output logic first,
	output logic last
);
	import fc_pkg::*;

	seq_state_e state;
	seq_state_e next_state;
	logic [ADDR_W-1:0] row;
	logic [ADDR_W-1:0] col;
	logic row_end;
	logic col_end;
	logic enable;

	assign enable = (state == seq_enable);
	assign col_end = (col == ADDR_W'(COLS - 1));
	assign row_end = (row == ADDR_W'(ROWS - 1));

	always_comb
	begin
		next_state = state;
		case (state)
			seq_idle:
			begin
				if (start)
				begin
					next_state = seq_setting;
				end
			end
			seq_setting:
			begin
				next_state = seq_enable;
			end
			seq_enable:
			begin
				if (row_end && col_end)
				begin
					next_state = seq_idle;
				end
			end
			default:
			begin
				next_state = seq_idle;
			end
		endcase
	end

	// counters wrap back to zero on the last address of a frame
	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			state <= seq_idle;
			row <= '0;
			col <= '0;
		end
		else
		begin
			state <= next_state;
			if (enable)
			begin
				if (col_end)
				begin
					col <= '0;
					if (row_end)
					begin
						row <= '0;
					end
					else
					begin
						row <= row + 1'b1;
					end
				end
				else
				begin
					col <= col + 1'b1;
				end
			end
		end
	end

	assign row_addr = row;
	assign col_addr = col;
	// flat index, column runs fastest
	assign weight_addr = ADDR_W'(row * COLS + col);

	assign read_pixel_signal = enable;
	assign issue = enable;
	assign first = enable && (row == '0) && (col == '0);
	assign last = enable && row_end && col_end;

endmodule

/* design/fc_bias_loader.sv */
module fc_bias_loader #(
	parameter int CHANNELS = 10
) (
	input logic clk,
	input logic rst,
	input logic load,
	input fc_pkg::word_t bias_data,
	output logic [fc_pkg::ADDR_W-1:0] read_bias_addr,
	output logic read_bias_signal,
	output logic bias_ready,
	output fc_pkg::word_t bias [CHANNELS]
);
	import fc_pkg::*;

	bias_state_e state;
	logic [ADDR_W-1:0] cnt;
	logic shift_en;
	logic reads_done;

	// one extra loading cycle lets the last word arrive
	assign reads_done = (cnt == ADDR_W'(CHANNELS));
	assign read_bias_signal = (state == bias_loading) && !reads_done;
	assign read_bias_addr = cnt;
	// the port hides the enum literal of the same name
	assign bias_ready = (state == fc_pkg::bias_ready);

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			state <= bias_idle;
			cnt <= '0;
			shift_en <= 1'b0;
		end
		else
		begin
			shift_en <= read_bias_signal;
			case (state)
				bias_loading:
				begin
					if (reads_done)
					begin
						state <= fc_pkg::bias_ready;
					end
					else
					begin
						cnt <= cnt + 1'b1;
					end
				end
				default:
				begin
					if (load)
					begin
						state <= bias_loading;
						cnt <= '0;
					end
				end
			endcase
		end
	end

	// words enter at the top slot, address k settles in channel k
	always_ff @(posedge clk)
	begin
		if (shift_en)
		begin
			bias[CHANNELS-1] <= bias_data;
			for (int i = 0; i < CHANNELS - 1; i++)
			begin
				bias[i] <= bias[i+1];
			end
		end
	end

endmodule

/* fc_array/fc_operand_stage.sv */
module fc_operand_stage #(
	parameter int CHANNELS = 10
) (
	input logic clk,
	input logic rst,
	input logic issue,
	input logic first,
	input logic last,
	input fc_pkg::word_t input_data,
	input logic [CHANNELS*fc_pkg::WORD_W-1:0] weight_data,
	input fc_pkg::word_t bias [CHANNELS],
	fc_lane_if.feeder lanes,
	output logic lane_last
);
	import fc_pkg::*;

	logic issue_d;
	logic first_d;
	logic last_d;

	// controls wait one cycle for the buffer data
	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			issue_d <= 1'b0;
			first_d <= 1'b0;
			last_d <= 1'b0;
			lanes.acc_en <= 1'b0;
			lanes.acc_first <= 1'b0;
			lane_last <= 1'b0;
		end
		else
		begin
			issue_d <= issue;
			first_d <= first;
			last_d <= last;
			lanes.acc_en <= issue_d;
			lanes.acc_first <= first_d;
			lane_last <= last_d;
		end
	end

	always_ff @(posedge clk)
	begin
		lanes.pixel <= input_data;
		for (int c = 0; c < CHANNELS; c++)
		begin
			lanes.weight[c] <= word_t'(weight_data[c*WORD_W +: WORD_W]);
			lanes.bias[c] <= bias[c];
		end
	end

endmodule

/* fc_array/fc_mac_lane.sv */
module fc_mac_lane #(
	parameter int CHANNEL = 0,
	parameter int CHANNELS = 10
) (
	input logic clk,
	input logic rst,
	fc_lane_if.lane lanes,
	output fc_pkg::word_t result
);
	import fc_pkg::*;

	// keep the select inside the interface arrays
	localparam int LANE_IDX = (CHANNEL < CHANNELS) ? CHANNEL : CHANNELS - 1;

	acc_t acc;
	acc_t product;
	acc_t bias_aligned;

	assign product = acc_t'(lanes.pixel) * acc_t'(lanes.weight[LANE_IDX]);
	assign bias_aligned = acc_t'(lanes.bias[LANE_IDX]) <<< FRAC_BITS;

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			acc <= '0;
		end
		else if (lanes.acc_en)
		begin
			if (lanes.acc_first)
			begin
				acc <= bias_aligned + product;
			end
			else
			begin
				acc <= acc + product;
			end
		end
	end

	// wraps, no rounding
	assign result = word_t'(acc[FRAC_BITS +: WORD_W]);

endmodule

/* fc_array/fc_result_collector.sv */
module fc_result_collector #(
	parameter int CHANNELS = 10
) (
	input logic clk,
	input logic rst,
	input logic lane_last,
	input fc_pkg::word_t results [CHANNELS],
	output logic [CHANNELS*fc_pkg::WORD_W-1:0] output_data,
	output logic calculation_done
);
	import fc_pkg::*;

	logic last_q;

	// lane results settle one cycle after the last accumulate
	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			last_q <= 1'b0;
			calculation_done <= 1'b0;
			output_data <= '0;
		end
		else
		begin
			last_q <= lane_last;
			calculation_done <= last_q;
			if (last_q)
			begin
				for (int c = 0; c < CHANNELS; c++)
				begin
					output_data[c*WORD_W +: WORD_W] <= results[c];
				end
			end
		end
	end

endmodule

/* design/fc_layer.sv */
module fc_layer #(
	parameter int ROWS = 5,
	parameter int COLS = 5,
	parameter int CHANNELS = 10
) (
	input logic clk,
	input logic rst,
	input logic pixel_store_done,
	input logic bias_store_done,
	input fc_pkg::word_t input_data,
	input logic [CHANNELS*fc_pkg::WORD_W-1:0] weight_data,
	input fc_pkg::word_t bias_data,
	output logic [fc_pkg::ADDR_W-1:0] read_row_addr,
	output logic [fc_pkg::ADDR_W-1:0] read_col_addr,
	output logic [fc_pkg::ADDR_W-1:0] read_weight_addr,
	output logic [fc_pkg::ADDR_W-1:0] read_bias_addr,
	output logic read_pixel_signal,
	output logic read_bias_signal,
	output logic [CHANNELS*fc_pkg::WORD_W-1:0] output_data,
	output logic calculation_done
);
	import fc_pkg::*;

	logic issue;
	logic first;
	logic last;
	logic lane_last;
	logic bias_ready;
	word_t bias [CHANNELS];
	word_t results [CHANNELS];

	fc_lane_if #(.CHANNELS(CHANNELS)) lanes ();

	fc_read_sequencer #(
		.ROWS(ROWS),
		.COLS(COLS)
	) i_sequencer (
		.clk(clk),
		.rst(rst),
		.start(pixel_store_done),
		.row_addr(read_row_addr),
		.col_addr(read_col_addr),
		.weight_addr(read_weight_addr),
		.read_pixel_signal(read_pixel_signal),
		.issue(issue),
		.first(first),
		.last(last)
	);

	fc_bias_loader #(.CHANNELS(CHANNELS)) i_bias_loader (
		.clk(clk),
		.rst(rst),
		.load(bias_store_done),
		.bias_data(bias_data),
		.read_bias_addr(read_bias_addr),
		.read_bias_signal(read_bias_signal),
		.bias_ready(bias_ready),
		.bias(bias)
	);

	fc_operand_stage #(.CHANNELS(CHANNELS)) i_operand_stage (
		.clk(clk),
		.rst(rst),
		.issue(issue),
		.first(first),
		.last(last),
		.input_data(input_data),
		.weight_data(weight_data),
		.bias(bias),
		.lanes(lanes.feeder),
		.lane_last(lane_last)
	);

	for (genvar c = 0; c < CHANNELS; c++)
	begin : g_lane
		fc_mac_lane #(
			.CHANNEL(c),
			.CHANNELS(CHANNELS)
		) i_lane (
			.clk(clk),
			.rst(rst),
			.lanes(lanes.lane),
			.result(results[c])
		);
	end

	fc_result_collector #(.CHANNELS(CHANNELS)) i_collector (
		.clk(clk),
		.rst(rst),
		.lane_last(lane_last),
		.results(results),
		.output_data(output_data),
		.calculation_done(calculation_done)
	);

endmodule

/* testbench/fc_layer_chk.sv */
module fc_layer_chk #(
	parameter int PIXELS = 25
) (
	input logic clk,
	input logic rst,
	input logic read_pixel_signal,
	input logic read_bias_signal,
	input logic bias_ready,
	input logic calculation_done
);

	int run_len;
	int failures;

	// length of the current strobe run
	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			run_len <= 0;
		end
		else if (read_pixel_signal)
		begin
			run_len <= run_len + 1;
		end
		else
		begin
			run_len <= 0;
		end
	end

	done_pulse: assert property (@(posedge clk) disable iff (rst)
		calculation_done |=> !calculation_done)
	else
	begin
		failures++;
		$error("calculation_done lasted more than one cycle");
	end

	strobe_len: assert property (@(posedge clk) disable iff (rst)
		$fell(read_pixel_signal) |-> run_len == PIXELS)
	else
	begin
		failures++;
		$error("read_pixel_signal run had the wrong length");
	end

	bias_quiet: assert property (@(posedge clk) disable iff (rst)
		bias_ready |-> !read_bias_signal)
	else
	begin
		failures++;
		$error("read_bias_signal while biases are ready");
	end

endmodule

bind fc_layer fc_layer_chk #(.PIXELS(ROWS * COLS)) i_chk (
	.clk(clk),
	.rst(rst),
	.read_pixel_signal(read_pixel_signal),
	.read_bias_signal(read_bias_signal),
	.bias_ready(bias_ready),
	.calculation_done(calculation_done)
);

/* testbench/fc_layer_tb.sv */
module fc_layer_tb;
	import fc_pkg::*;

	localparam int ROWS = 3;
	localparam int COLS = 3;
	localparam int CHANNELS = 4;
	localparam int PIXELS = ROWS * COLS;
	// reload flag, biases, pixels, weights, expected results
	localparam int FRAME_WORDS = 1 + CHANNELS + PIXELS + PIXELS * CHANNELS + CHANNELS;
	localparam int FRAMES = 4;
	localparam int TIMEOUT = 200;

	logic clk;
	logic rst;
	logic pixel_store_done;
	logic bias_store_done;
	word_t input_data;
	logic [CHANNELS*WORD_W-1:0] weight_data;
	word_t bias_data;
	logic [ADDR_W-1:0] read_row_addr;
	logic [ADDR_W-1:0] read_col_addr;
	logic [ADDR_W-1:0] read_weight_addr;
	logic [ADDR_W-1:0] read_bias_addr;
	logic read_pixel_signal;
	logic read_bias_signal;
	logic [CHANNELS*WORD_W-1:0] output_data;
	logic calculation_done;

	logic [WORD_W-1:0] patterns [FRAMES*FRAME_WORDS];
	word_t pixel_buf [PIXELS];
	word_t weight_buf [PIXELS*CHANNELS];
	word_t bias_buf [CHANNELS];
	logic [CHANNELS*WORD_W-1:0] expected_q [$];
	int last_strobe_q [$];
	int cycle;
	int pixel_idx;
	int bias_idx;
	logic [31:0] rnd_state;

	fc_layer #(
		.ROWS(ROWS),
		.COLS(COLS),
		.CHANNELS(CHANNELS)
	) i_dut (
		.clk(clk),
		.rst(rst),
		.pixel_store_done(pixel_store_done),
		.bias_store_done(bias_store_done),
		.input_data(input_data),
		.weight_data(weight_data),
		.bias_data(bias_data),
		.read_row_addr(read_row_addr),
		.read_col_addr(read_col_addr),
		.read_weight_addr(read_weight_addr),
		.read_bias_addr(read_bias_addr),
		.read_pixel_signal(read_pixel_signal),
		.read_bias_signal(read_bias_signal),
		.output_data(output_data),
		.calculation_done(calculation_done)
	);

	initial
	begin
		clk = 1'b0;
	end

	always #2 clk = ~clk;

	always @(posedge clk)
	begin
		cycle <= cycle + 1;
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	task automatic report_failure(input string what);
		$display("%s", what);
		$display("Finished with errors");
		$fatal(1, "simulation stopped");
	endtask

	// buffers answer one cycle after the strobe
	always @(posedge clk)
	begin
		if (read_pixel_signal)
		begin
			input_data <= pixel_buf[read_row_addr * COLS + read_col_addr];
			for (int c = 0; c < CHANNELS; c++)
			begin
				weight_data[c*WORD_W +: WORD_W] <= weight_buf[read_weight_addr * CHANNELS + c];
			end
		end
		if (read_bias_signal)
		begin
			bias_data <= bias_buf[read_bias_addr];
		end
	end

	// address order and result checks
	always @(negedge clk)
	begin
		assert (i_dut.i_chk.failures == 0)
		else report_failure("a bound timing assertion failed");
		if (!rst && read_pixel_signal)
		begin
			assert (read_row_addr == ADDR_W'(pixel_idx / COLS))
			else report_failure($sformatf("Fail at %0t: read_row_addr expected %0d got %0d",
				$time, pixel_idx / COLS, read_row_addr));
			assert (read_col_addr == ADDR_W'(pixel_idx % COLS))
			else report_failure($sformatf("Fail at %0t: read_col_addr expected %0d got %0d",
				$time, pixel_idx % COLS, read_col_addr));
			assert (read_weight_addr == ADDR_W'(pixel_idx))
			else report_failure($sformatf("Fail at %0t: read_weight_addr expected %0d got %0d",
				$time, pixel_idx, read_weight_addr));
			if (pixel_idx == PIXELS - 1)
			begin
				last_strobe_q.push_back(cycle);
			end
			pixel_idx <= (pixel_idx + 1) % PIXELS;
		end
		if (!rst && read_bias_signal)
		begin
			assert (read_bias_addr == ADDR_W'(bias_idx))
			else report_failure($sformatf("Fail at %0t: read_bias_addr expected %0d got %0d",
				$time, bias_idx, read_bias_addr));
			bias_idx <= (bias_idx + 1) % CHANNELS;
		end
		if (!rst && calculation_done)
		begin
			assert (expected_q.size() > 0 && last_strobe_q.size() > 0)
			else report_failure("calculation_done pulsed with no frame in flight");
			assert (cycle == last_strobe_q[0] + 4)
			else report_failure($sformatf("Fail at %0t: calculation_done cycle expected %0d got %0d",
				$time, last_strobe_q[0] + 4, cycle));
			assert (output_data == expected_q[0])
			else report_failure($sformatf("Fail at %0t: output_data expected %h got %h",
				$time, expected_q[0], output_data));
			void'(expected_q.pop_front());
			void'(last_strobe_q.pop_front());
		end
	end

	task automatic check_quiet_outputs();
		assert (!read_pixel_signal && !read_bias_signal && !calculation_done)
		else report_failure("a strobe or calculation_done is active before any stimulus");
		assert (output_data == '0)
		else report_failure($sformatf("Fail at %0t: output_data expected 0 got %h",
			$time, output_data));
	endtask

	// delay counts from the pulse cycle, len is the strobe run length
	task automatic strobe_window(input bit bias_side, output int delay, output int len);
		int guard;
		delay = 1;
		len = 0;
		guard = 0;
		@(negedge clk);
		while (!(bias_side ? read_bias_signal : read_pixel_signal))
		begin
			guard++;
			assert (guard < TIMEOUT) else report_failure("timeout waiting for a read strobe");
			delay++;
			@(negedge clk);
		end
		while (bias_side ? read_bias_signal : read_pixel_signal)
		begin
			len++;
			assert (len < TIMEOUT) else report_failure("read strobe never went low");
			@(negedge clk);
		end
	endtask

	task automatic wait_results_drained();
		int guard;
		guard = 0;
		while (expected_q.size() > 0)
		begin
			guard++;
			assert (guard < TIMEOUT) else report_failure("timeout waiting for calculation_done");
			@(negedge clk);
		end
	endtask

	task automatic load_biases(input int base);
		int delay;
		int len;
		wait_results_drained();
		for (int c = 0; c < CHANNELS; c++)
		begin
			bias_buf[c] = patterns[base + 1 + c];
		end
		@(posedge clk);
		bias_store_done <= 1'b1;
		@(posedge clk);
		bias_store_done <= 1'b0;
		strobe_window(1'b1, delay, len);
		assert (len == CHANNELS)
		else report_failure($sformatf("Fail at %0t: read_bias_signal cycles expected %0d got %0d",
			$time, CHANNELS, len));
	endtask

	task automatic run_frame(input int base);
		logic [CHANNELS*WORD_W-1:0] expected;
		int delay;
		int len;
		for (int i = 0; i < PIXELS; i++)
		begin
			pixel_buf[i] = patterns[base + 1 + CHANNELS + i];
		end
		for (int i = 0; i < PIXELS * CHANNELS; i++)
		begin
			weight_buf[i] = patterns[base + 1 + CHANNELS + PIXELS + i];
		end
		for (int c = 0; c < CHANNELS; c++)
		begin
			expected[c*WORD_W +: WORD_W] = patterns[base + FRAME_WORDS - CHANNELS + c];
		end
		expected_q.push_back(expected);
		@(posedge clk);
		pixel_store_done <= 1'b1;
		@(posedge clk);
		pixel_store_done <= 1'b0;
		strobe_window(1'b0, delay, len);
		assert (delay == 2)
		else report_failure($sformatf("Fail at %0t: read_pixel_signal delay expected 2 got %0d",
			$time, delay));
		assert (len == PIXELS)
		else report_failure($sformatf("Fail at %0t: read_pixel_signal cycles expected %0d got %0d",
			$time, PIXELS, len));
	endtask

	initial
	begin
		int gap;
		int base;
		rst = 1'b1;
		pixel_store_done = 1'b0;
		bias_store_done = 1'b0;
		input_data = '0;
		weight_data = '0;
		bias_data = '0;
		cycle = 0;
		pixel_idx = 0;
		bias_idx = 0;
		rnd_state = 32'hcf642799;
		$readmemh("testbench/fc_layer_patterns.txt", patterns);
		for (int i = 0; i < 16; i++)
		begin
			@(negedge clk);
			check_quiet_outputs();
		end
		@(posedge clk);
		rst <= 1'b0;
		repeat (2)
		begin
			@(negedge clk);
			check_quiet_outputs();
		end
		for (int f = 0; f < FRAMES; f++)
		begin
			base = f * FRAME_WORDS;
			rnd_state = xorshift32(rnd_state);
			// second frame starts right away to overlap the pipeline
			gap = (f == 1) ? 0 : int'(rnd_state % 8);
			repeat (gap) @(posedge clk);
			if (patterns[base] != '0)
			begin
				load_biases(base);
			end
			run_frame(base);
		end
		wait_results_drained();
		// the pulse check of the last frame completes two edges later
		repeat (2) @(negedge clk);
		if (i_dut.i_chk.failures == 0)
		begin
			$display("Finished with no errors");
			$finish;
		end
		else
		begin
			report_failure("a bound timing assertion failed");
		end
	end

endmodule

/* testbench/fc_layer_patterns.txt */
// per frame: reload flag, 4 biases, 9 pixels, 9 x 4 weights (address, then channel),
// 4 expected results; all words Q8.8 hex
// frame 0
0001
0100 0200 FF00 0000
0100 0200 0300 FF00 0080 0000 0200 0100 FE00
0100 0080 FF00 0100  0100 0080 FF00 0000  0100 0080 FF00 0100
0100 0080 FF00 0000  0100 0080 FF00 0100  0100 0080 FF00 0000
0100 0080 FF00 0100  0100 0080 FF00 0000  0100 0080 FF00 0100
0780 0540 F880 0480
// frame 1, same biases
0000
0100 0200 FF00 0000
0040 0040 0040 0040 0040 0040 0040 0040 0040
0200 0040 FF80 0100  0200 0040 FF80 0100  0200 0040 FF80 0100
0200 0040 FF80 0000  0200 0040 FF80 0000  0200 0040 FF80 0000
0200 0040 FF80 0000  0200 0040 FF80 0000  0200 0040 FF80 0000
0580 0290 FDE0 00C0
// frame 2, results wrap
0000
0100 0200 FF00 0000
7F00 7F00 7F00 7F00 7F00 7F00 7F00 7F00 7F00
7F00 0000 0100 FF00  7F00 0000 0100 FF00  7F00 0000 0100 FF00
7F00 0000 0100 FF00  7F00 0000 0100 FF00  7F00 0000 0100 FF00
7F00 0000 0100 FF00  7F00 0000 0100 FF00  7F00 0000 0100 FF00
0A00 0200 7600 8900
// frame 3, new biases
0001
0300 FE00 0080 1000
0100 0100 0100 0100 0100 0100 0100 0100 0100
0100 0100 0100 0100  0100 0100 0100 0100  0100 0100 0100 0100
0100 0100 0100 0100  0100 0100 0100 0100  0100 0100 0100 0100
0100 0100 0100 0100  0100 0100 0100 0100  0100 0100 0100 0100
0C00 0700 0980 1900

/* fc_layer.f */
common/fc_pkg.sv
common/fc_lane_if.sv
design/fc_read_sequencer.sv
design/fc_bias_loader.sv
fc_array/fc_operand_stage.sv
fc_array/fc_mac_lane.sv
fc_array/fc_result_collector.sv
design/fc_layer.sv
testbench/fc_layer_chk.sv
testbench/fc_layer_tb.sv

/* Makefile */
VERILATOR ?= verilator
FLAGS     ?= --binary --assert --timing -Wall
TOP       ?= fc_layer_tb
FILELIST  ?= fc_layer.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; \
	cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "Finished with errors" $(LOG); then \
		echo "simulation failed"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
